// ==== verilog/dma_cfg_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Descriptor DMA constants: bus widths, register map and the
// layout of a descriptor in memory
////////////////////////////////////////////////////////////////////////////

package dma_cfg_pkg;

  localparam int unsigned ADDR_W = 32;  // Byte address, word aligned
  localparam int unsigned DATA_W = 32;
  localparam int unsigned LEN_W  = 16;  // Descriptor length in words
  localparam int unsigned CNT_W  = 16;  // Completed-descriptor count

  localparam logic [ADDR_W-1:0] WORD_BYTES = 32'd4;

  // Register map
  localparam int unsigned           REG_ADDR_W    = 4;
  localparam logic [REG_ADDR_W-1:0] REG_DESC_ADDR = 4'h0;  // Write starts a chain
  localparam logic [REG_ADDR_W-1:0] REG_STATUS    = 4'h4;  // Bit 0 busy, 31:16 count
  localparam logic [REG_ADDR_W-1:0] REG_IRQ_CLR   = 4'h8;

  // Control, source and destination in consecutive words.
  // The next descriptor of a chain follows directly
  localparam int unsigned DESC_WORDS = 3;

endpackage

// ==== verilog/dma_bus_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Register-bus and memory-bus structs, descriptor control word
// union and the descriptor passed from fetch to copy
////////////////////////////////////////////////////////////////////////////

package dma_bus_pkg;

  import dma_cfg_pkg::*;

  // Single-cycle register strobe, always accepted
  typedef struct packed {
    logic                  valid;
    logic                  write;
    logic [REG_ADDR_W-1:0] addr;
    logic [DATA_W-1:0]     wdata;
  } reg_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] rdata;  // Valid the cycle after a read strobe
  } reg_rsp_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic              we;
    logic [DATA_W-1:0] wdata;
  } mem_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] rdata;
  } mem_rsp_t;

  typedef struct packed {
    logic                    last;  // End of chain
    logic                    irq;
    logic [DATA_W-LEN_W-3:0] rsvd;
    logic [LEN_W-1:0]        len;   // Words
  } dma_ctrl_t;

  // Raw word as read from memory, or its decoded fields
  typedef union packed {
    logic [DATA_W-1:0] raw;
    dma_ctrl_t         ctrl;
  } dma_ctrl_u;

  typedef struct packed {
    dma_ctrl_u         ctrl;
    logic [ADDR_W-1:0] src;
    logic [ADDR_W-1:0] dst;
  } dma_desc_t;

endpackage

// ==== verilog/dma_reg_block.sv ====
////////////////////////////////////////////////////////////////////////////
// Software registers: doorbell with start pulse, status with done
// counter, interrupt level and its clear
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dma_reg_block (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  dma_bus_pkg::reg_req_t          reg_req_i,
  output dma_bus_pkg::reg_rsp_t          reg_rsp_o,
  input  logic                           busy_i,
  input  logic                           done_i,
  input  logic                           done_irq_i,
  output logic                           start_o,
  output logic [dma_cfg_pkg::ADDR_W-1:0] start_addr_o,
  output logic                           irq_o
);

  import dma_cfg_pkg::*;

  logic              wr_desc;
  logic              wr_irq_clr;
  logic              rd_stb;
  logic              start_ok;
  logic [CNT_W-1:0]  done_cnt_q;
  logic [DATA_W-1:0] rdata;

  assign wr_desc    = reg_req_i.valid & reg_req_i.write & (reg_req_i.addr == REG_DESC_ADDR);
  assign wr_irq_clr = reg_req_i.valid & reg_req_i.write & (reg_req_i.addr == REG_IRQ_CLR);
  assign rd_stb     = reg_req_i.valid & ~reg_req_i.write;
  // Busy only rises the cycle after the pulse, so block back-to-back writes too
  assign start_ok   = wr_desc & ~busy_i & ~start_o;

  always_comb begin
    case (reg_req_i.addr)
      REG_DESC_ADDR: rdata = start_addr_o;
      REG_STATUS:    rdata = {done_cnt_q, {(DATA_W-CNT_W-1){1'b0}}, busy_i};
      default:       rdata = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      start_o    <= 1'b0;
      done_cnt_q <= '0;
      irq_o      <= 1'b0;
    end else begin
      start_o <= start_ok;
      if (done_i) done_cnt_q <= done_cnt_q + 1'b1;
      if (done_i & done_irq_i) begin
        irq_o <= 1'b1;
      end else if (wr_irq_clr) begin
        irq_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_ok) start_addr_o <= reg_req_i.wdata;
    if (rd_stb) reg_rsp_o.rdata <= rdata;
  end

  // A dropped doorbell never reaches the fetch FSM
  assert property (@(posedge clk_i) disable iff (!rst_n_i) start_o |-> !busy_i)
    else $error("start pulse while the engine is busy");

endmodule

// ==== verilog/dma_desc_fsm.sv ====
////////////////////////////////////////////////////////////////////////////
// Descriptor fetch FSM: reads three-word descriptors from a running
// pointer, offers them to the copy engine and prefetches the next one
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dma_desc_fsm (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic                           start_i,
  input  logic [dma_cfg_pkg::ADDR_W-1:0] start_addr_i,
  output logic                           busy_o,
  output dma_bus_pkg::dma_desc_t         desc_o,
  output logic                           desc_valid_o,
  input  logic                           desc_ready_i,
  input  logic                           done_i,
  output dma_bus_pkg::mem_req_t          mem_req_o,
  output logic                           mem_req_valid_o,
  input  logic                           mem_req_ready_i,
  input  dma_bus_pkg::mem_rsp_t          mem_rsp_i,
  input  logic                           mem_rsp_valid_i
);

  import dma_cfg_pkg::*;

  localparam int unsigned IdxW = $clog2(DESC_WORDS + 1);

  typedef enum logic [2:0] {idle, issue, collect, offer, wait_slot} state_e;

  state_e            state_q;
  state_e            state_d;
  logic [ADDR_W-1:0] ptr_q;
  logic [IdxW-1:0]   iss_cnt_q;
  logic [IdxW-1:0]   rsp_cnt_q;
  logic              req_hs;

  assign req_hs          = mem_req_valid_o & mem_req_ready_i;
  assign mem_req_valid_o = (state_q == issue);
  assign mem_req_o.addr  = ptr_q;
  assign mem_req_o.we    = 1'b0;
  assign mem_req_o.wdata = '0;
  assign desc_valid_o    = (state_q == offer);
  assign busy_o          = (state_q != idle);

  always_comb begin
    state_d = state_q;
    case (state_q)
      idle: begin
        if (start_i) state_d = issue;
      end
      issue: begin
        if (req_hs && iss_cnt_q == IdxW'(DESC_WORDS - 1)) state_d = collect;
      end
      collect: begin
        if (rsp_cnt_q == IdxW'(DESC_WORDS)) state_d = offer;
      end
      offer: begin
        // Prefetch the next one while this one is copied
        if (desc_ready_i) state_d = desc_o.ctrl.ctrl.last ? wait_slot : issue;
      end
      wait_slot: begin
        if (done_i) state_d = idle;  // Completion of the last descriptor
      end
      default: state_d = idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q   <= idle;
      iss_cnt_q <= '0;
      rsp_cnt_q <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == idle || state_q == offer) begin
        iss_cnt_q <= '0;
        rsp_cnt_q <= '0;
      end else begin
        if (req_hs) iss_cnt_q <= iss_cnt_q + 1'b1;
        if (mem_rsp_valid_i) rsp_cnt_q <= rsp_cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == idle && start_i) begin
      ptr_q <= start_addr_i;
    end else if (req_hs) begin
      ptr_q <= ptr_q + WORD_BYTES;
    end
    if (mem_rsp_valid_i) begin
      case (rsp_cnt_q)
        IdxW'(0): desc_o.ctrl.raw <= mem_rsp_i.rdata;
        IdxW'(1): desc_o.src      <= mem_rsp_i.rdata;
        default:  desc_o.dst      <= mem_rsp_i.rdata;
      endcase
    end
  end

  // Arbiter must route only responses to reads issued here
  assert property (@(posedge clk_i) disable iff (!rst_n_i) rsp_cnt_q <= iss_cnt_q)
    else $error("descriptor response without an issued read");

endmodule

// ==== verilog/dma_xfer_counter.sv ====
////////////////////////////////////////////////////////////////////////////
// Remaining-word counter with source and destination address stepping
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dma_xfer_counter (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic                           load_i,
  input  logic                           step_i,
  input  logic [dma_cfg_pkg::LEN_W-1:0]  len_i,
  input  logic [dma_cfg_pkg::ADDR_W-1:0] src_i,
  input  logic [dma_cfg_pkg::ADDR_W-1:0] dst_i,
  output logic [dma_cfg_pkg::ADDR_W-1:0] src_addr_o,
  output logic [dma_cfg_pkg::ADDR_W-1:0] dst_addr_o,
  output logic                           last_o,
  output logic                           empty_o
);

  import dma_cfg_pkg::*;

  logic [LEN_W-1:0] cnt_q;

  assign empty_o = (cnt_q == '0);
  assign last_o  = (cnt_q == LEN_W'(1));  // One word left

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else if (load_i) begin
      cnt_q <= len_i;
    end else if (step_i) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_i) begin
      src_addr_o <= src_i;
      dst_addr_o <= dst_i;
    end else if (step_i) begin
      src_addr_o <= src_addr_o + WORD_BYTES;
      dst_addr_o <= dst_addr_o + WORD_BYTES;
    end
  end

  // Copy engine stops before the count wraps
  assert property (@(posedge clk_i) disable iff (!rst_n_i) step_i |-> !empty_o)
    else $error("step with no words left");

endmodule

// ==== verilog/dma_copy_engine.sv ====
////////////////////////////////////////////////////////////////////////////
// Copy engine: per word a source read, the response into the data
// register, then the destination write
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dma_copy_engine (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  dma_bus_pkg::dma_desc_t desc_i,
  input  logic                   desc_valid_i,
  output logic                   desc_ready_o,
  output logic                   done_o,
  output logic                   done_irq_o,
  output dma_bus_pkg::mem_req_t  mem_req_o,
  output logic                   mem_req_valid_o,
  input  logic                   mem_req_ready_i,
  input  dma_bus_pkg::mem_rsp_t  mem_rsp_i,
  input  logic                   mem_rsp_valid_i
);

  import dma_cfg_pkg::*;
  import dma_bus_pkg::*;

  typedef enum logic [1:0] {idle, rd_req, rd_wait, wr_req} state_e;

  state_e            state_q;
  dma_ctrl_u         ctrl_q;  // Control word of the active descriptor
  logic [DATA_W-1:0] data_q;
  logic [ADDR_W-1:0] src_addr;
  logic [ADDR_W-1:0] dst_addr;
  logic              load;
  logic              step;
  logic              last;
  logic              empty;
  logic              req_hs;

  assign desc_ready_o    = (state_q == idle);
  assign load            = desc_valid_i & desc_ready_o;
  assign req_hs          = mem_req_valid_o & mem_req_ready_i;
  assign step            = (state_q == wr_req) & req_hs;
  assign mem_req_valid_o = ((state_q == rd_req) & ~empty) | (state_q == wr_req);
  assign mem_req_o.addr  = (state_q == wr_req) ? dst_addr : src_addr;
  assign mem_req_o.we    = (state_q == wr_req);
  assign mem_req_o.wdata = data_q;
  // Zero length ends right after the accept, otherwise on the last write
  assign done_o          = ((state_q == rd_req) & empty) | (step & last);
  assign done_irq_o      = ctrl_q.ctrl.irq;

  dma_xfer_counter xfer_counter_i (
    .clk_i,
    .rst_n_i,
    .load_i     ( load                   ),
    .step_i     ( step                   ),
    .len_i      ( desc_i.ctrl.ctrl.len   ),
    .src_i      ( desc_i.src             ),
    .dst_i      ( desc_i.dst             ),
    .src_addr_o ( src_addr               ),
    .dst_addr_o ( dst_addr               ),
    .last_o     ( last                   ),
    .empty_o    ( empty                  )
  );

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= idle;
    end else begin
      case (state_q)
        idle: begin
          if (load) state_q <= rd_req;
        end
        rd_req: begin
          if (empty) begin
            state_q <= idle;
          end else if (req_hs) begin
            state_q <= rd_wait;
          end
        end
        rd_wait: begin
          if (mem_rsp_valid_i) state_q <= wr_req;
        end
        default: begin
          if (step) state_q <= last ? idle : rd_req;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) ctrl_q <= desc_i.ctrl;
    if (state_q == rd_wait && mem_rsp_valid_i) data_q <= mem_rsp_i.rdata;
  end

endmodule

// ==== verilog/dma_mem_arbiter.sv ====
////////////////////////////////////////////////////////////////////////////
// Round-robin merge of two memory masters, owner queue routing the
// in-order read responses back
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dma_mem_arbiter #(
  parameter int unsigned MaxOutstanding = 2
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  dma_bus_pkg::mem_req_t m0_req_i,
  input  logic                  m0_valid_i,
  output logic                  m0_ready_o,
  output logic                  m0_rsp_valid_o,
  input  dma_bus_pkg::mem_req_t m1_req_i,
  input  logic                  m1_valid_i,
  output logic                  m1_ready_o,
  output logic                  m1_rsp_valid_o,
  output dma_bus_pkg::mem_req_t mem_req_o,
  output logic                  mem_req_valid_o,
  input  logic                  mem_req_ready_i,
  input  logic                  mem_rsp_valid_i
);

  localparam int unsigned PtrW = (MaxOutstanding > 1) ? $clog2(MaxOutstanding) : 1;
  localparam int unsigned CntW = $clog2(MaxOutstanding + 1);

  logic [1:0]      vld;
  logic            gnt;
  logic            gnt_q;
  logic            lock_q;
  logic            prio_q;
  logic            full;
  logic            push;
  logic            pop;
  logic            owner_q [MaxOutstanding];  // 1 means master 1
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [CntW-1:0] cnt_q;

  // Reads wait while the owner queue is full
  assign full   = (cnt_q == CntW'(MaxOutstanding));
  assign vld[0] = m0_valid_i & (m0_req_i.we | ~full);
  assign vld[1] = m1_valid_i & (m1_req_i.we | ~full);

  always_comb begin
    if (lock_q) begin
      gnt = gnt_q;  // Stalled request keeps its grant
    end else if (&vld) begin
      gnt = prio_q;
    end else begin
      gnt = vld[1];
    end
  end

  assign mem_req_o       = gnt ? m1_req_i : m0_req_i;
  assign mem_req_valid_o = vld[gnt];
  assign m0_ready_o      = mem_req_ready_i & ~gnt & vld[0];
  assign m1_ready_o      = mem_req_ready_i & gnt & vld[1];
  assign push            = mem_req_valid_o & mem_req_ready_i & ~mem_req_o.we;
  assign pop             = mem_rsp_valid_i;
  assign m0_rsp_valid_o  = pop & ~owner_q[rd_ptr_q];
  assign m1_rsp_valid_o  = pop & owner_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      gnt_q    <= 1'b0;
      lock_q   <= 1'b0;
      prio_q   <= 1'b0;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      gnt_q  <= gnt;
      lock_q <= mem_req_valid_o & ~mem_req_ready_i;
      if (mem_req_valid_o & mem_req_ready_i) prio_q <= ~gnt;
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(MaxOutstanding - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(MaxOutstanding - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push != pop) cnt_q <= push ? cnt_q + 1'b1 : cnt_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) owner_q[wr_ptr_q] <= gnt;
  end

  // Memory answers reads only
  assert property (@(posedge clk_i) disable iff (!rst_n_i) mem_rsp_valid_i |-> cnt_q != '0)
    else $error("memory response with no read outstanding");

endmodule

// ==== verilog/dma_desc_top.sv ====
////////////////////////////////////////////////////////////////////////////
// Descriptor DMA top: register block, fetch FSM, copy engine and the
// arbiter onto the single memory master port
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dma_desc_top #(
  parameter int unsigned MaxOutstanding = 2
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  dma_bus_pkg::reg_req_t reg_req_i,
  output dma_bus_pkg::reg_rsp_t reg_rsp_o,
  output logic                  irq_o,
  output dma_bus_pkg::mem_req_t mem_req_o,
  output logic                  mem_req_valid_o,
  input  logic                  mem_req_ready_i,
  input  dma_bus_pkg::mem_rsp_t mem_rsp_i,
  input  logic                  mem_rsp_valid_i
);

  import dma_cfg_pkg::*;
  import dma_bus_pkg::*;

  logic              start;
  logic [ADDR_W-1:0] start_addr;
  logic              busy;
  logic              done;
  logic              done_irq;
  dma_desc_t         desc;
  logic              desc_valid;
  logic              desc_ready;
  mem_req_t          fetch_req;
  logic              fetch_valid;
  logic              fetch_ready;
  logic              fetch_rsp_valid;
  mem_req_t          copy_req;
  logic              copy_valid;
  logic              copy_ready;
  logic              copy_rsp_valid;

  dma_reg_block reg_block_i (
    .clk_i,
    .rst_n_i,
    .reg_req_i,
    .reg_rsp_o,
    .busy_i       ( busy       ),
    .done_i       ( done       ),
    .done_irq_i   ( done_irq   ),
    .start_o      ( start      ),
    .start_addr_o ( start_addr ),
    .irq_o
  );

  dma_desc_fsm desc_fsm_i (
    .clk_i,
    .rst_n_i,
    .start_i         ( start           ),
    .start_addr_i    ( start_addr      ),
    .busy_o          ( busy            ),
    .desc_o          ( desc            ),
    .desc_valid_o    ( desc_valid      ),
    .desc_ready_i    ( desc_ready      ),
    .done_i          ( done            ),
    .mem_req_o       ( fetch_req       ),
    .mem_req_valid_o ( fetch_valid     ),
    .mem_req_ready_i ( fetch_ready     ),
    .mem_rsp_i,
    .mem_rsp_valid_i ( fetch_rsp_valid )
  );

  dma_copy_engine copy_engine_i (
    .clk_i,
    .rst_n_i,
    .desc_i          ( desc           ),
    .desc_valid_i    ( desc_valid     ),
    .desc_ready_o    ( desc_ready     ),
    .done_o          ( done           ),
    .done_irq_o      ( done_irq       ),
    .mem_req_o       ( copy_req       ),
    .mem_req_valid_o ( copy_valid     ),
    .mem_req_ready_i ( copy_ready     ),
    .mem_rsp_i,
    .mem_rsp_valid_i ( copy_rsp_valid )
  );

  // Fetch is master 0, copy is master 1
  dma_mem_arbiter #(
    .MaxOutstanding ( MaxOutstanding )
  ) mem_arbiter_i (
    .clk_i,
    .rst_n_i,
    .m0_req_i       ( fetch_req       ),
    .m0_valid_i     ( fetch_valid     ),
    .m0_ready_o     ( fetch_ready     ),
    .m0_rsp_valid_o ( fetch_rsp_valid ),
    .m1_req_i       ( copy_req        ),
    .m1_valid_i     ( copy_valid      ),
    .m1_ready_o     ( copy_ready      ),
    .m1_rsp_valid_o ( copy_rsp_valid  ),
    .mem_req_o,
    .mem_req_valid_o,
    .mem_req_ready_i,
    .mem_rsp_valid_i
  );

endmodule

// ==== verif/dma_desc_tb.sv ====
////////////////////////////////////////////////////////////////////////////
// Descriptor DMA testbench: clock and reset, memory model with random
// back-pressure, register driver, golden-file runner and watchdog
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dma_desc_tb;

  import dma_cfg_pkg::*;
  import dma_bus_pkg::*;

  localparam string       GOLDEN   = "verif/dma_golden.txt";
  localparam int unsigned MEM_WORDS = 1024;
  localparam int unsigned MAX_LAT  = 4;  // Longest read response latency

  logic        clk;
  logic        rst_n;
  reg_req_t    reg_req;
  reg_rsp_t    reg_rsp;
  logic        irq;
  mem_req_t    mem_req;
  logic        mem_req_valid;
  logic        mem_req_ready;
  mem_rsp_t    mem_rsp;
  logic        mem_rsp_valid;

  logic [31:0] mem [MEM_WORDS];
  logic        pend;           // One read in flight
  logic [31:0] pend_data;
  int unsigned pend_lat;
  integer      seed = 32'h7df01b2e;
  int unsigned limit_cycles = 0;

  dma_desc_top #(
    .MaxOutstanding ( 2 )
  ) dma_desc_top_i (
    .clk_i           ( clk           ),
    .rst_n_i         ( rst_n         ),
    .reg_req_i       ( reg_req       ),
    .reg_rsp_o       ( reg_rsp       ),
    .irq_o           ( irq           ),
    .mem_req_o       ( mem_req       ),
    .mem_req_valid_o ( mem_req_valid ),
    .mem_req_ready_i ( mem_req_ready ),
    .mem_rsp_i       ( mem_rsp       ),
    .mem_rsp_valid_i ( mem_rsp_valid )
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic fail_run();
    $display("Testbench failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("[FAIL] %0t %s: actual %08h expected %08h", $time, name, actual, expected);
      fail_run();
    end
  endtask

  task automatic write_reg(input logic [REG_ADDR_W-1:0] addr, input logic [31:0] data);
    @(negedge clk);
    reg_req = '{valid: 1'b1, write: 1'b1, addr: addr, wdata: data};
    @(negedge clk);
    reg_req.valid = 1'b0;
  endtask

  // Read data is registered on the edge after the strobe
  task automatic read_reg(input logic [REG_ADDR_W-1:0] addr, output logic [31:0] data);
    @(negedge clk);
    reg_req = '{valid: 1'b1, write: 1'b0, addr: addr, wdata: '0};
    @(negedge clk);
    reg_req.valid = 1'b0;
    data = reg_rsp.rdata;
  endtask

  task automatic wait_idle();
    logic [31:0] status;
    do begin
      read_reg(REG_STATUS, status);
    end while (status[0]);
  endtask

  task automatic count_lines(output int unsigned n);
    integer fd;
    integer c;
    n = 0;
    fd = $fopen(GOLDEN, "r");
    if (fd == 0) begin
      $display("Cannot open the golden file %s", GOLDEN);
      fail_run();
    end
    c = $fgetc(fd);
    while (c != -1) begin
      if (c == 10) n++;
      c = $fgetc(fd);
    end
    $fclose(fd);
  endtask

  // Memory model: ready and response are decided on the falling edge,
  // a request seen here transfers on the next rising edge
  initial begin
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = (i << 2) ^ 32'h5a5a0000;  // Word at byte address a holds a ^ 5a5a0000
    end
    mem_req_ready = 1'b0;
    mem_rsp       = '0;
    mem_rsp_valid = 1'b0;
    pend          = 1'b0;
    pend_data     = '0;
    pend_lat      = 0;
  end

  always @(negedge clk) begin : mem_model
    logic [9:0] idx;
    mem_rsp_valid = 1'b0;
    if (!rst_n) begin
      mem_req_ready = 1'b0;
    end else begin
      if (pend) begin
        pend_lat = pend_lat - 1;
        if (pend_lat == 0) begin
          mem_rsp.rdata = pend_data;
          mem_rsp_valid = 1'b1;
          pend          = 1'b0;
        end
      end
      mem_req_ready = !pend && (($unsigned($random(seed)) % 4) != 0);
      if (mem_req_valid && mem_req_ready) begin
        if (mem_req.addr[1:0] != 2'b00 || mem_req.addr >= MEM_WORDS * 4) begin
          $display("Memory access outside the model or unaligned at %08h", mem_req.addr);
          fail_run();
        end else begin
          idx = mem_req.addr[11:2];
          if (mem_req.we) begin
            mem[idx] = mem_req.wdata;
          end else begin
            pend      = 1'b1;
            pend_data = mem[idx];
            pend_lat  = 1 + ($unsigned($random(seed)) % MAX_LAT);
          end
        end
      end
    end
  end

  initial begin : watchdog
    wait (limit_cycles != 0);
    repeat (limit_cycles) @(posedge clk);
    $display("Watchdog expired: the DMA did not finish within %0d cycles", limit_cycles);
    fail_run();
  end

  initial begin : main
    integer          fd;
    integer          code;
    integer          c;
    int unsigned     n_lines;
    logic [7:0]      op;
    logic [31:0]     a0;
    logic [31:0]     a1;
    logic [31:0]     a2;
    logic [31:0]     a3;
    logic [31:0]     status;
    rst_n   = 1'b0;
    reg_req = '0;
    count_lines(n_lines);
    limit_cycles = 200 * n_lines * MAX_LAT;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    fd = $fopen(GOLDEN, "r");
    code = $fscanf(fd, " %c", op);
    while (code == 1) begin
      case (op)
        "#": begin
          c = $fgetc(fd);
          while (c != 10 && c != -1) c = $fgetc(fd);
        end
        "D": begin  // Place control, source and destination words
          code = $fscanf(fd, "%h %h %h %h", a0, a1, a2, a3);
          mem[a3[11:2]]     = a0;
          mem[a3[11:2] + 1] = a1;
          mem[a3[11:2] + 2] = a2;
        end
        "S": begin
          code = $fscanf(fd, "%h", a0);
          write_reg(REG_DESC_ADDR, a0);
        end
        "W": wait_idle();
        "E": begin
          code = $fscanf(fd, "%h %h", a0, a1);
          check_value($sformatf("mem[%08h]", a0), mem[a0[11:2]], a1);
        end
        "C": begin
          code = $fscanf(fd, "%h", a0);
          read_reg(REG_STATUS, status);
          check_value("status.count", {16'h0, status[31:16]}, a0);
        end
        "Q": begin
          code = $fscanf(fd, "%h", a0);
          @(negedge clk);
          check_value("irq_o", {31'h0, irq}, a0);
        end
        "X": write_reg(REG_IRQ_CLR, 32'h0);
        default: begin
          $display("Unknown command '%c' in the golden file", op);
          fail_run();
        end
      endcase
      code = $fscanf(fd, " %c", op);
    end
    $fclose(fd);
    $display("Testbench passed");
    $finish;
  end

endmodule

// ==== verif/dma_golden.txt ====
# D ctrl src dst place | S desc addr | W wait idle | E addr word | C count | Q irq | X irq clear
# Memory starts as word(a) = a ^ 5a5a0000, all values in hex
D 80000008 00000400 00000800 00000100
S 00000100
W
E 00000800 5a5a0400
E 00000810 5a5a0410
E 0000081c 5a5a041c
E 00000820 5a5a0820
C 1
Q 0
D 00000004 00000480 00000900 00000110
D 40000002 000004c0 00000940 0000011c
D 80000003 00000500 00000980 00000128
S 00000110
W
E 00000900 5a5a0480
E 0000090c 5a5a048c
E 00000944 5a5a04c4
E 00000988 5a5a0508
E 0000098c 5a5a098c
C 4
Q 1
X
Q 0
D 80000000 00000600 00000a00 00000140
S 00000140
W
E 00000a00 5a5a0a00
C 5
Q 0
D 80000010 00000640 00000a40 00000150
D 80000004 000006c0 00000b00 00000160
S 00000150
S 00000160
W
E 00000a40 5a5a0640
E 00000a7c 5a5a067c
E 00000b00 5a5a0b00
E 00000b0c 5a5a0b0c
C 6
Q 0

// ==== project.f ====
verilog/dma_cfg_pkg.sv
verilog/dma_bus_pkg.sv
verilog/dma_reg_block.sv
verilog/dma_desc_fsm.sv
verilog/dma_xfer_counter.sv
verilog/dma_copy_engine.sv
verilog/dma_mem_arbiter.sv
verilog/dma_desc_top.sv
verif/dma_desc_tb.sv

// ==== Bender.yml ====
package:
  name: dma_desc

sources:
  - files:
      - verilog/dma_cfg_pkg.sv
      - verilog/dma_bus_pkg.sv
      - verilog/dma_reg_block.sv
      - verilog/dma_desc_fsm.sv
      - verilog/dma_xfer_counter.sv
      - verilog/dma_copy_engine.sv
      - verilog/dma_mem_arbiter.sv
      - verilog/dma_desc_top.sv
  - target: test
    files:
      - verif/dma_desc_tb.sv
